/* src/page_pkg.sv */
/*
 * Page management unit shared definitions
 * Widths, data types, APB register offsets, FLAGS bit positions
 * and the reprioritize fill state encoding
 */
`default_nettype none

package page_pkg;

    // ------------------------------------------------
    // Sizes
    // ------------------------------------------------
    localparam int PAGE_BITS       = 10;            // Physical and virtual page number
    localparam int OFFSET_BITS     = 10;            // Word offset inside a page
    localparam int BESM6_PAGE_BITS = 5;             // Page bits used in BESM-6 mode
    localparam int PAGE_COUNT      = 1024;          // Entries in each page memory

    // ------------------------------------------------
    // Types
    // ------------------------------------------------
    typedef logic [PAGE_BITS-1:0]             page_num_t;   // Page number
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] map_entry_t;  // Phys page in 19:10
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] phys_addr_t;  // Physical address
    typedef logic [31:0]                      virt_addr_t;  // Virtual address
    typedef logic [11:0]                      apb_addr_t;   // APB byte address
    typedef logic [31:0]                      apb_data_t;   // APB data word

    typedef enum logic {
        FILL_IDLE,                                  // No fill in progress
        FILL_RUN                                    // Writing ones, one page per cycle
    } fill_state_t;

    // ------------------------------------------------
    // Register map
    // ------------------------------------------------
    localparam apb_addr_t REG_CTRL       = 12'h000; // bit0 no_paging, bit1 besm6
    localparam apb_addr_t REG_PAGE_INDEX = 12'h004; // Physical page index, bits 9:0
    localparam apb_addr_t REG_MAP        = 12'h008; // Map entry at PAGE_INDEX
    localparam apb_addr_t REG_FLAGS      = 12'h00C; // Used and dirty at PAGE_INDEX
    localparam apb_addr_t REG_REPRIO     = 12'h010; // Reprioritize bit at PAGE_INDEX
    localparam apb_addr_t REG_FILL       = 12'h014; // Write starts fill, read busy

    localparam int FLAG_USED_BIT  = 1;              // Page referenced
    localparam int FLAG_DIRTY_BIT = 2;              // Page modified

endpackage

`default_nettype wire

/* src/page_access_if.sv */
/*
 * Indexed access bundle from the register block to the page map
 * and the status bit memories
 */
`timescale 1ns/1ps
`default_nettype none

interface page_access_if;

    page_pkg::page_num_t  index;        // Current PAGE_INDEX
    page_pkg::apb_data_t  wdata;        // APB write data
    logic                 map_we;       // Write map entry at index
    logic                 flags_we;     // Write used/dirty at index
    logic                 reprio_we;    // Write reprioritize bit at index
    logic                 fill_start;   // Start bulk fill from index

    page_pkg::map_entry_t map_rdata;    // Map entry at index
    logic                 used_rdata;   // Used bit at index
    logic                 dirty_rdata;  // Dirty bit at index
    logic                 reprio_rdata; // Reprioritize bit at index
    logic                 fill_busy;    // Fill sequence running

    modport csr (output index, wdata, map_we, flags_we, reprio_we, fill_start,
                 input  map_rdata, used_rdata, dirty_rdata, reprio_rdata, fill_busy);

    modport map (input  index, wdata, map_we,
                 output map_rdata);

    modport status (input  index, wdata, flags_we, reprio_we, fill_start,
                    output used_rdata, dirty_rdata, reprio_rdata, fill_busy);

endinterface

`default_nettype wire

/* src/page_csr.sv */
/*
 * APB slave for the page unit
 * Offset decode into memory write strobes, CTRL and PAGE_INDEX
 * registers, read data selection and error response
 */
`timescale 1ns/1ps
`default_nettype none

module page_csr (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_psel,
    input  wire                  i_penable,
    input  wire                  i_pwrite,
    input  page_pkg::apb_addr_t  i_paddr,
    input  page_pkg::apb_data_t  i_pwdata,
    output page_pkg::apb_data_t  o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    input  wire                  i_upd_valid,     // Translation update this cycle
    input  page_pkg::page_num_t  i_upd_page,      // Translated page
    output logic                 o_no_paging,
    output logic                 o_besm6,
    page_access_if.csr           mem
);

    logic                access;                // APB access phase
    logic                wr;                    // Write access phase
    logic                hit;                   // Offset is mapped
    page_pkg::page_num_t page_index;            // Physical page index register

    assign access = i_psel & i_penable;
    assign wr     = access & i_pwrite;

    assign o_pready  = access;                  // No wait states
    assign o_pslverr = access & ~hit;

    // --------------------------------------------------
    // Write strobes to the memories
    // --------------------------------------------------
    assign mem.index      = page_index;
    assign mem.wdata      = i_pwdata;
    assign mem.map_we     = wr & (i_paddr == page_pkg::REG_MAP);
    assign mem.flags_we   = wr & (i_paddr == page_pkg::REG_FLAGS);
    assign mem.reprio_we  = wr & (i_paddr == page_pkg::REG_REPRIO);
    assign mem.fill_start = wr & (i_paddr == page_pkg::REG_FILL);

    // Mode bits
    always_ff @(posedge clk) begin
        if (reset) begin
            o_no_paging <= 1'b0;
            o_besm6     <= 1'b0;
        end else if (wr && i_paddr == page_pkg::REG_CTRL) begin
            o_no_paging <= i_pwdata[0];
            o_besm6     <= i_pwdata[1];
        end
    end

    // Translation reloads the index ahead of the host
    always_ff @(posedge clk) begin
        if (reset)
            page_index <= '0;
        else if (i_upd_valid)
            page_index <= i_upd_page;
        else if (wr && i_paddr == page_pkg::REG_PAGE_INDEX)
            page_index <= i_pwdata[page_pkg::PAGE_BITS-1:0];
    end

    // --------------------------------------------------
    // Read data
    // --------------------------------------------------
    always_comb begin
        o_prdata = '0;
        hit      = 1'b1;
        case (i_paddr)
            page_pkg::REG_CTRL: begin
                o_prdata[0] = o_no_paging;
                o_prdata[1] = o_besm6;
            end
            page_pkg::REG_PAGE_INDEX:
                o_prdata = page_pkg::apb_data_t'(page_index);
            page_pkg::REG_MAP:
                o_prdata = page_pkg::apb_data_t'(mem.map_rdata);
            page_pkg::REG_FLAGS: begin                  // bit0 reads 0
                o_prdata[page_pkg::FLAG_USED_BIT]  = mem.used_rdata;
                o_prdata[page_pkg::FLAG_DIRTY_BIT] = mem.dirty_rdata;
            end
            page_pkg::REG_REPRIO:
                o_prdata[0] = mem.reprio_rdata;
            page_pkg::REG_FILL:
                o_prdata[0] = mem.fill_busy;
            default:
                hit = 1'b0;                             // Unmapped, reads 0
        endcase
    end

endmodule

`default_nettype wire

/* src/page_translator.sv */
/*
 * Page map memory with host read/write port and the
 * one-cycle virtual to physical translation pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module page_translator (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_req,           // Translation request
    input  wire                  i_req_write,     // Request is a write access
    input  page_pkg::virt_addr_t i_vaddr,
    input  wire                  i_no_paging,
    input  wire                  i_besm6,
    output logic                 o_phys_valid,
    output page_pkg::phys_addr_t o_physad,
    output logic                 o_upd_valid,     // Update index and flags at this edge
    output page_pkg::page_num_t  o_upd_page,
    output logic                 o_upd_write,
    page_access_if.map           mem
);

    localparam int PB = page_pkg::PAGE_BITS;
    localparam int OB = page_pkg::OFFSET_BITS;

    page_pkg::map_entry_t pg_map [page_pkg::PAGE_COUNT];  // Page map
    page_pkg::page_num_t  pg_virt;                        // Virtual page
    page_pkg::page_num_t  pg_translated;                  // Physical page
    page_pkg::map_entry_t map_entry;                      // Entry for pg_virt

    // --------------------------------------------------
    // Host access at PAGE_INDEX
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (mem.map_we)
            pg_map[mem.index] <= mem.wdata[PB+OB-1:0];
    end

    assign mem.map_rdata = pg_map[mem.index];

    // --------------------------------------------------
    // Translation
    // --------------------------------------------------
    // BESM-6 addresses span 15 bits, so only five page bits count
    assign pg_virt = i_besm6
        ? {{(PB-page_pkg::BESM6_PAGE_BITS){1'b0}}, i_vaddr[OB +: page_pkg::BESM6_PAGE_BITS]}
        : i_vaddr[OB +: PB];

    assign map_entry     = pg_map[pg_virt];
    assign pg_translated = i_no_paging ? pg_virt : map_entry[OB +: PB];   // Bypass or lookup

    // Index and flag updates land at the same edge as the result
    assign o_upd_valid = i_req;
    assign o_upd_page  = pg_translated;
    assign o_upd_write = i_req & i_req_write;

    always_ff @(posedge clk) begin
        if (reset)
            o_phys_valid <= 1'b0;
        else
            o_phys_valid <= i_req;                  // One cycle after request
    end

    always_ff @(posedge clk) begin
        if (i_req)
            o_physad <= {pg_translated, i_vaddr[OB-1:0]};   // Page plus word offset
    end

endmodule

`default_nettype wire

/* src/page_status_mem.sv */
/*
 * Per-page used, dirty and reprioritize bit memories
 * Translation sets used/dirty, the host reads and writes them,
 * and a sequencer fills reprioritize bits with ones
 */
`timescale 1ns/1ps
`default_nettype none

module page_status_mem (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_upd_valid,     // Translation update
    input  page_pkg::page_num_t  i_upd_page,      // Page being referenced
    input  wire                  i_upd_write,     // Reference is a write
    page_access_if.status        mem
);

    logic                   pg_used   [page_pkg::PAGE_COUNT];   // Page referenced
    logic                   pg_dirty  [page_pkg::PAGE_COUNT];   // Page modified
    logic                   pg_reprio [page_pkg::PAGE_COUNT];   // Reprioritize request

    page_pkg::fill_state_t  fill_state;
    page_pkg::page_num_t    fill_cnt;                           // Next page to fill
    logic                   fill_last;                          // Filling page 1023

    assign fill_last = (fill_cnt == page_pkg::page_num_t'(page_pkg::PAGE_COUNT - 1));

    // --------------------------------------------------
    // Used and dirty bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_upd_valid) begin                      // Translation wins over host
            pg_used[i_upd_page] <= 1'b1;
            if (i_upd_write)
                pg_dirty[i_upd_page] <= 1'b1;
        end else if (mem.flags_we) begin
            pg_used[mem.index]  <= mem.wdata[page_pkg::FLAG_USED_BIT];
            pg_dirty[mem.index] <= mem.wdata[page_pkg::FLAG_DIRTY_BIT];
        end
    end

    assign mem.used_rdata  = pg_used[mem.index];
    assign mem.dirty_rdata = pg_dirty[mem.index];

    // --------------------------------------------------
    // Fill sequencer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_state <= page_pkg::FILL_IDLE;
            fill_cnt   <= '0;
        end else begin
            case (fill_state)
                page_pkg::FILL_IDLE:
                    if (mem.fill_start) begin
                        fill_state <= page_pkg::FILL_RUN;
                        fill_cnt   <= mem.index;    // Start at current PAGE_INDEX
                    end
                page_pkg::FILL_RUN:
                    if (fill_last)
                        fill_state <= page_pkg::FILL_IDLE;
                    else
                        fill_cnt <= fill_cnt + 1'b1;
                default:
                    fill_state <= page_pkg::FILL_IDLE;
            endcase
        end
    end

    assign mem.fill_busy = (fill_state == page_pkg::FILL_RUN);

    // Host writes are dropped while filling or when a translation hits
    always_ff @(posedge clk) begin
        if (mem.fill_busy)
            pg_reprio[fill_cnt] <= 1'b1;
        else if (mem.reprio_we && !i_upd_valid)
            pg_reprio[mem.index] <= mem.wdata[0];
    end

    assign mem.reprio_rdata = pg_reprio[mem.index];

endmodule

`default_nettype wire

/* src/page_unit.sv */
/*
 * Page management unit top level
 * APB register block, page map translator and status memories
 */
`timescale 1ns/1ps
`default_nettype none

module page_unit (
    input  wire                  clk,
    input  wire                  reset,
    // APB slave
    input  wire                  i_psel,
    input  wire                  i_penable,
    input  wire                  i_pwrite,
    input  page_pkg::apb_addr_t  i_paddr,
    input  page_pkg::apb_data_t  i_pwdata,
    output page_pkg::apb_data_t  o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    // Translation port
    input  wire                  i_req,
    input  wire                  i_req_write,
    input  page_pkg::virt_addr_t i_vaddr,
    output logic                 o_phys_valid,
    output page_pkg::phys_addr_t o_physad
);

    logic                no_paging;         // Mapping bypass
    logic                besm6;             // Five page bits only
    logic                upd_valid;
    page_pkg::page_num_t upd_page;
    logic                upd_write;

    page_access_if mem_if ();

    page_csr u_csr (
        .clk(clk), .reset(reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_upd_valid(upd_valid), .i_upd_page(upd_page),
        .o_no_paging(no_paging), .o_besm6(besm6),
        .mem(mem_if.csr)
    );

    page_translator u_translator (
        .clk(clk), .reset(reset),
        .i_req(i_req), .i_req_write(i_req_write), .i_vaddr(i_vaddr),
        .i_no_paging(no_paging), .i_besm6(besm6),
        .o_phys_valid(o_phys_valid), .o_physad(o_physad),
        .o_upd_valid(upd_valid), .o_upd_page(upd_page), .o_upd_write(upd_write),
        .mem(mem_if.map)
    );

    page_status_mem u_status (
        .clk(clk), .reset(reset),
        .i_upd_valid(upd_valid), .i_upd_page(upd_page), .i_upd_write(upd_write),
        .mem(mem_if.status)
    );

endmodule

`default_nettype wire

/* include/tb_apb_tasks.svh */
/*
 * Testbench helpers for the page unit
 * APB write and read transfers, typed compare tasks, xorshift generator
 */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_data(input string name, input page_pkg::apb_data_t actual,
                          input page_pkg::apb_data_t expected);
    if (actual !== expected)
        abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
endtask

task automatic check_phys(input string name, input page_pkg::phys_addr_t actual,
                          input page_pkg::phys_addr_t expected);
    if (actual !== expected)
        abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
        abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                            $time, name, actual, expected));
endtask

// --------------------------------------------------
// APB transfers
// --------------------------------------------------
task automatic apb_write(input page_pkg::apb_addr_t addr, input page_pkg::apb_data_t data,
                         output logic err);
    @(negedge clk);
    psel    = 1'b1;                                 // Setup cycle
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;                                 // Access cycle
    #SAMPLE_DELAY;
    check_bit("o_pready", pready, 1'b1);            // No wait states expected
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;                                 // Write landed at the last rising edge
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input page_pkg::apb_addr_t addr, output page_pkg::apb_data_t data,
                        output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #SAMPLE_DELAY;                                  // Read data is combinational here
    check_bit("o_pready", pready, 1'b1);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// Xorshift32 step on the shared generator state
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

`endif

/* sim/tb_page_unit.sv */
/*
 * Page unit testbench top
 * Clock, reset, watchdog, reference page map and directed tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_page_unit;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int SAMPLE_DELAY    = 2;         // Quarter period after the falling edge
    localparam int APB_CYCLES      = 3;         // Setup, access and idle per transfer
    localparam int FILL_LIMIT      = 2000;      // Poll bound for the fill, in cycles
    localparam int WATCHDOG_CYCLES = 20000;     // Fill bound plus directed traffic and margin
    localparam int MAPPED_PAGES    = 32;        // Covers every BESM-6 page

    logic                 clk;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    page_pkg::apb_addr_t  paddr;
    page_pkg::apb_data_t  pwdata;
    page_pkg::apb_data_t  prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 req;
    logic                 req_write;
    page_pkg::virt_addr_t vaddr;
    logic                 phys_valid;
    page_pkg::phys_addr_t physad;

    page_pkg::map_entry_t map_model [MAPPED_PAGES];     // Entries written to the map
    logic [31:0]          rng_state;

    page_unit dut (
        .clk(clk), .reset(reset),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .i_req(req), .i_req_write(req_write), .i_vaddr(vaddr),
        .o_phys_valid(phys_valid), .o_physad(physad)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    `include "tb_apb_tasks.svh"

    task automatic reg_write(input page_pkg::apb_addr_t addr, input page_pkg::apb_data_t data);
        logic err;
        apb_write(addr, data, err);
        check_bit("o_pslverr", err, 1'b0);
    endtask

    task automatic reg_read_check(input page_pkg::apb_addr_t addr,
                                  input page_pkg::apb_data_t expected);
        page_pkg::apb_data_t rdata;
        logic                err;
        apb_read(addr, rdata, err);
        check_bit("o_pslverr", err, 1'b0);
        check_data($sformatf("o_prdata @%h", addr), rdata, expected);
    endtask

    // Translation rule for the mode bits programmed in CTRL
    function automatic page_pkg::phys_addr_t expected_phys(input page_pkg::virt_addr_t va,
                                                           input logic nopg, input logic besm);
        page_pkg::page_num_t vp;
        vp = besm ? page_pkg::page_num_t'(va[14:10]) : va[19:10];
        if (nopg)
            return {vp, va[9:0]};                       // Bypass keeps the virtual page
        return {map_model[vp][19:10], va[9:0]};
    endfunction

    // Back-to-back requests with each result checked one cycle later
    task automatic run_requests(input page_pkg::virt_addr_t va_q[$], input logic is_write,
                                input logic nopg, input logic besm);
        page_pkg::phys_addr_t exp_q[$];
        for (int i = 0; i <= va_q.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_bit("o_phys_valid", phys_valid, 1'b1);
                check_phys("o_physad", physad, exp_q[i-1]);
            end
            if (i < va_q.size()) begin
                req       = 1'b1;
                req_write = is_write;
                vaddr     = va_q[i];
                exp_q.push_back(expected_phys(va_q[i], nopg, besm));
            end else begin
                req       = 1'b0;
                req_write = 1'b0;
            end
        end
        @(negedge clk);
        check_bit("o_phys_valid", phys_valid, 1'b0);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        reg_read_check(page_pkg::REG_CTRL, 0);
        reg_read_check(page_pkg::REG_PAGE_INDEX, 0);
        reg_read_check(page_pkg::REG_FILL, 0);              // Not busy
        repeat (4) begin
            @(negedge clk);
            check_bit("o_phys_valid", phys_valid, 1'b0);    // No request, no result
        end
    endtask

    task automatic test_map_access();
        page_pkg::apb_data_t rdata;
        logic                err;
        for (int p = 0; p < MAPPED_PAGES; p++) begin
            map_model[p] = page_pkg::map_entry_t'(next_random());
            reg_write(page_pkg::REG_PAGE_INDEX, p);
            reg_write(page_pkg::REG_MAP, page_pkg::apb_data_t'(map_model[p]));
        end
        for (int p = 0; p < MAPPED_PAGES; p++) begin
            reg_write(page_pkg::REG_PAGE_INDEX, p);
            reg_read_check(page_pkg::REG_MAP, page_pkg::apb_data_t'(map_model[p]));
        end
        reg_write(page_pkg::REG_PAGE_INDEX, 5);
        reg_write(page_pkg::REG_FLAGS, 32'h7);              // bit0 is not stored
        reg_read_check(page_pkg::REG_FLAGS, 32'h6);
        reg_write(page_pkg::REG_FLAGS, 32'h4);              // Dirty only
        reg_read_check(page_pkg::REG_FLAGS, 32'h4);
        apb_read(12'h020, rdata, err);                      // Unmapped offset
        check_bit("o_pslverr", err, 1'b1);
        check_data("o_prdata @020", rdata, 0);
        apb_write(12'h020, 32'hFFFF_FFFF, err);
        check_bit("o_pslverr", err, 1'b1);
    endtask

    task automatic test_translation();
        page_pkg::virt_addr_t va_q[$];
        page_pkg::virt_addr_t va;
        reg_write(page_pkg::REG_CTRL, 0);                   // Paging on, normal mode
        repeat (8) begin
            va        = next_random();
            va[19:15] = '0;                                 // Stay in mapped pages
            va_q.push_back(va);
        end
        run_requests(va_q, 1'b0, 1'b0, 1'b0);
        va_q.delete();
        reg_write(page_pkg::REG_CTRL, 32'h2);               // BESM-6 mode ignores bits 19:15
        repeat (8) va_q.push_back(next_random());
        run_requests(va_q, 1'b0, 1'b0, 1'b1);
        va_q.delete();
        reg_write(page_pkg::REG_CTRL, 32'h1);               // No paging
        repeat (8) va_q.push_back(next_random());
        run_requests(va_q, 1'b0, 1'b1, 1'b0);
        reg_write(page_pkg::REG_CTRL, 0);
    endtask

    task automatic test_used_dirty();
        page_pkg::page_num_t  tp;
        page_pkg::virt_addr_t va_q[$];
        tp = map_model[3][19:10];                           // Physical page of virtual page 3
        va_q.push_back(32'h0000_0C55);
        reg_write(page_pkg::REG_PAGE_INDEX, page_pkg::apb_data_t'(tp));
        reg_write(page_pkg::REG_FLAGS, 0);
        reg_write(page_pkg::REG_PAGE_INDEX, page_pkg::apb_data_t'(tp ^ 10'h1));
        run_requests(va_q, 1'b0, 1'b0, 1'b0);               // Read reference
        reg_read_check(page_pkg::REG_PAGE_INDEX, page_pkg::apb_data_t'(tp));
        reg_read_check(page_pkg::REG_FLAGS, 1 << page_pkg::FLAG_USED_BIT);
        run_requests(va_q, 1'b1, 1'b0, 1'b0);               // Write reference
        reg_read_check(page_pkg::REG_FLAGS,
                       (1 << page_pkg::FLAG_USED_BIT) | (1 << page_pkg::FLAG_DIRTY_BIT));
    endtask

    task automatic test_fill();
        page_pkg::apb_data_t rdata;
        logic                err;
        int                  cycles;
        reg_write(page_pkg::REG_PAGE_INDEX, 999);
        reg_write(page_pkg::REG_REPRIO, 0);
        reg_write(page_pkg::REG_PAGE_INDEX, 1000);
        reg_write(page_pkg::REG_REPRIO, 0);
        reg_write(page_pkg::REG_FILL, 1);                   // Fill from page 1000
        cycles = 0;
        rdata  = '1;
        while (rdata[0] && cycles < FILL_LIMIT) begin
            apb_read(page_pkg::REG_FILL, rdata, err);
            check_bit("o_pslverr", err, 1'b0);
            cycles += APB_CYCLES;
        end
        if (rdata[0])
            abort_run("Fill never finished: busy still set after 2000 cycles");
        for (int p = 1000; p < page_pkg::PAGE_COUNT; p++) begin
            reg_write(page_pkg::REG_PAGE_INDEX, p);
            reg_read_check(page_pkg::REG_REPRIO, 1);
        end
        reg_write(page_pkg::REG_PAGE_INDEX, 999);           // Below the start page
        reg_read_check(page_pkg::REG_REPRIO, 0);
    endtask

    // --------------------------------------------------
    // Clock, watchdog and test sequence
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Watchdog expired: the tests did not finish in time");
    end

    initial begin
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        req       = 1'b0;
        req_write = 1'b0;
        vaddr     = '0;
        rng_state = 32'd97254;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_values();
        test_map_access();
        test_translation();
        test_used_dirty();
        test_fill();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
src/page_pkg.sv
src/page_access_if.sv
src/page_csr.sv
src/page_translator.sv
src/page_status_mem.sv
src/page_unit.sv
sim/tb_page_unit.sv

/* Makefile */
# Verilator build and run for the page management unit testbench

VERILATOR ?= verilator
TOP       ?= tb_page_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv sim/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
